// File: src/trap_cfg.svh
/*
 * Trap unit configuration
 * Register width, machine cause numbers and CSR bit positions
 */
`ifndef TRAP_CFG_SVH
`define TRAP_CFG_SVH

`define TRAP_XLEN 32

// Interrupt cause numbers, also the enable bit positions in a mie write
`define TRAP_INT_SOFT  3
`define TRAP_INT_TIMER 7
`define TRAP_INT_EXT   11

// Synchronous exception cause numbers
`define TRAP_EX_INSN_MAL    0
`define TRAP_EX_INSN_ACCESS 1
`define TRAP_EX_ILLEGAL     2
`define TRAP_EX_BREAKPOINT  3
`define TRAP_EX_LOAD_MAL    4
`define TRAP_EX_LOAD_FAULT  5
`define TRAP_EX_STORE_MAL   6
`define TRAP_EX_STORE_FAULT 7
`define TRAP_EX_ECALL_M     11

`define TRAP_MSTATUS_MIE  3   // mstatus.mie position in a CSR write
`define TRAP_MSTATUS_MPIE 7   // mstatus.mpie position in a CSR write

// Bit order of the 3-bit mip and mie_bits vectors
`define TRAP_IP_SOFT  0
`define TRAP_IP_TIMER 1
`define TRAP_IP_EXT   2

`endif

// File: src/trap_pkg.sv
/*
 * Trap unit types
 * Cause enums, the two-view mcause word and the CSR write select
 */
`default_nettype none

`include "trap_cfg.svh"

package trap_pkg;

    // Machine interrupt causes
    typedef enum logic [3:0] {
        INT_SOFT  = 4'(`TRAP_INT_SOFT),
        INT_TIMER = 4'(`TRAP_INT_TIMER),
        INT_EXT   = 4'(`TRAP_INT_EXT)
    } int_code_t;

    // Synchronous exception causes, machine mode only
    typedef enum logic [4:0] {
        EX_INSN_MAL    = 5'(`TRAP_EX_INSN_MAL),
        EX_INSN_ACCESS = 5'(`TRAP_EX_INSN_ACCESS),
        EX_ILLEGAL     = 5'(`TRAP_EX_ILLEGAL),
        EX_BREAKPOINT  = 5'(`TRAP_EX_BREAKPOINT),
        EX_LOAD_MAL    = 5'(`TRAP_EX_LOAD_MAL),
        EX_LOAD_FAULT  = 5'(`TRAP_EX_LOAD_FAULT),
        EX_STORE_MAL   = 5'(`TRAP_EX_STORE_MAL),
        EX_STORE_FAULT = 5'(`TRAP_EX_STORE_FAULT),
        EX_ECALL_M     = 5'(`TRAP_EX_ECALL_M)
    } ex_code_t;

    // mcause seen as an interrupt (top bit set)
    typedef struct packed {
        logic                    intr;
        logic [`TRAP_XLEN-6:0]   pad;
        int_code_t               code;
    } mcause_int_t;

    // mcause seen as an exception (top bit clear)
    typedef struct packed {
        logic                    intr;
        logic [`TRAP_XLEN-7:0]   pad;
        ex_code_t                code;
    } mcause_ex_t;

    typedef union packed {
        mcause_int_t irq;
        mcause_ex_t  exc;
    } mcause_u;

    // Target of the software write port
    typedef enum logic {
        CSR_MSTATUS = 1'b0,
        CSR_MIE     = 1'b1
    } csr_sel_t;

endpackage

`default_nettype wire

// File: src/int_prioritizer.sv
/*
 * Machine interrupt prioritizer
 * Holds mip and the mie enables, picks the most urgent enabled
 * pending interrupt (external, then software, then timer)
 */
`timescale 1ns/1ns
`default_nettype none

`include "trap_cfg.svh"

module int_prioritizer (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   ext_irq,
    input  logic                   soft_irq,
    input  logic                   timer_irq,
    input  logic                   clr_ext,
    input  logic                   clr_soft,
    input  logic                   clr_timer,
    input  logic                   csr_write,
    input  trap_pkg::csr_sel_t     csr_sel,
    input  logic [`TRAP_XLEN-1:0]  csr_wdata,
    output logic [2:0]             mip,
    output logic [2:0]             mie_bits,
    output logic                   int_pending,
    output trap_pkg::int_code_t    int_code
);

    logic [2:0] irq_line;
    logic [2:0] irq_clr;
    logic [2:0] active;     // Pending and enabled

    assign irq_line = {ext_irq, timer_irq, soft_irq};   // Ordered by TRAP_IP_* index
    assign irq_clr  = {clr_ext, clr_timer, clr_soft};

    // Pending bits, a high line beats a clear pulse
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mip <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (irq_line[i])
                    mip[i] <= 1'b1;
                else if (irq_clr[i])
                    mip[i] <= 1'b0;
            end
        end
    end

    // Enable bits sit at their cause positions in the write data
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mie_bits <= '0;
        end else if (csr_write && csr_sel == trap_pkg::CSR_MIE) begin
            mie_bits[`TRAP_IP_EXT]   <= csr_wdata[`TRAP_INT_EXT];
            mie_bits[`TRAP_IP_TIMER] <= csr_wdata[`TRAP_INT_TIMER];
            mie_bits[`TRAP_IP_SOFT]  <= csr_wdata[`TRAP_INT_SOFT];
        end
    end

    assign active      = mip & mie_bits;
    assign int_pending = |active;

    // Fixed priority pick
    always_comb begin
        int_code = trap_pkg::INT_SOFT;  // Don't care when nothing is active
        if (active[`TRAP_IP_EXT])
            int_code = trap_pkg::INT_EXT;
        else if (active[`TRAP_IP_SOFT])
            int_code = trap_pkg::INT_SOFT;
        else if (active[`TRAP_IP_TIMER])
            int_code = trap_pkg::INT_TIMER;
    end

endmodule

`default_nettype wire

// File: src/ex_prioritizer.sv
/*
 * Synchronous exception prioritizer
 * Priority chain over the nine exception flags, also forms the
 * trap value that the winning exception records in mtval
 */
`timescale 1ns/1ns
`default_nettype none

`include "trap_cfg.svh"

module ex_prioritizer (
    input  logic                   breakpoint,
    input  logic                   insn_access,
    input  logic                   illegal_insn,
    input  logic                   insn_mal,
    input  logic                   ecall_m,
    input  logic                   store_mal,
    input  logic                   load_mal,
    input  logic                   store_fault,
    input  logic                   load_fault,
    input  logic [`TRAP_XLEN-1:0]  bad_value,
    output logic                   ex_valid,
    output trap_pkg::ex_code_t     ex_code,
    output logic [`TRAP_XLEN-1:0]  ex_tval
);

    logic keep_tval;    // Winner records bad_value

    always_comb begin
        ex_valid  = 1'b1;
        keep_tval = 1'b1;
        ex_code   = trap_pkg::EX_INSN_MAL;

        if (breakpoint) begin
            ex_code   = trap_pkg::EX_BREAKPOINT;
            keep_tval = 1'b0;   // No faulting value
        end else if (insn_access) begin
            ex_code = trap_pkg::EX_INSN_ACCESS;
        end else if (illegal_insn) begin
            ex_code = trap_pkg::EX_ILLEGAL;         // bad_value holds the instruction
        end else if (insn_mal) begin
            ex_code = trap_pkg::EX_INSN_MAL;
        end else if (ecall_m) begin
            ex_code   = trap_pkg::EX_ECALL_M;
            keep_tval = 1'b0;
        end else if (store_mal) begin
            ex_code = trap_pkg::EX_STORE_MAL;
        end else if (load_mal) begin
            ex_code = trap_pkg::EX_LOAD_MAL;
        end else if (store_fault) begin
            ex_code = trap_pkg::EX_STORE_FAULT;
        end else if (load_fault) begin
            ex_code = trap_pkg::EX_LOAD_FAULT;
        end else begin
            // Nothing raised
            ex_valid  = 1'b0;
            keep_tval = 1'b0;
        end
    end

    assign ex_tval = keep_tval ? bad_value : '0;

endmodule

`default_nettype wire

// File: src/trap_ctrl.sv
/*
 * Trap control
 * Chooses exception, interrupt or nothing each cycle, records the
 * trap CSRs once on the taking edge, and holds trap for a taken
 * interrupt until the pipeline is cleared
 */
`timescale 1ns/1ns
`default_nettype none

`include "trap_cfg.svh"

module trap_ctrl (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   int_pending,
    input  trap_pkg::int_code_t    int_code,
    input  logic                   ex_valid,
    input  trap_pkg::ex_code_t     ex_code,
    input  logic [`TRAP_XLEN-1:0]  ex_tval,
    input  logic [`TRAP_XLEN-1:0]  epc,
    input  logic                   mret,
    input  logic                   pipe_clear,
    input  logic                   csr_write,
    input  trap_pkg::csr_sel_t     csr_sel,
    input  logic [`TRAP_XLEN-1:0]  csr_wdata,
    output logic                   trap,
    output trap_pkg::mcause_u      mcause,
    output logic [`TRAP_XLEN-1:0]  mepc,
    output logic [`TRAP_XLEN-1:0]  mtval,
    output logic                   mstatus_mie,
    output logic                   mstatus_mpie
);

    logic take_ex;      // Exception taken this cycle
    logic take_int;     // Interrupt taken this cycle
    logic trap_taken;
    logic int_taken;    // Interrupt recorded, waiting for pipe_clear
    logic mstatus_wr;

    // An exception always wins over a same-cycle interrupt
    assign take_ex    = ex_valid;
    assign take_int   = !ex_valid && mstatus_mie && int_pending;
    assign trap_taken = take_ex | take_int;
    assign mstatus_wr = csr_write && csr_sel == trap_pkg::CSR_MSTATUS;

    // Exceptions reach the pipeline in the same cycle, interrupts one later
    assign trap = ex_valid | int_taken;

    // Cause register, one view written per trap kind
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mcause <= '0;
        end else if (take_ex) begin
            mcause.exc.intr <= 1'b0;
            mcause.exc.pad  <= '0;
            mcause.exc.code <= ex_code;
        end else if (take_int) begin
            mcause.irq.intr <= 1'b1;
            mcause.irq.pad  <= '0;
            mcause.irq.code <= int_code;
        end
    end

    // Return address, written once per trap
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            mepc <= '0;
        else if (trap_taken)
            mepc <= epc;
    end

    // Trap value only from exceptions, interrupts leave it alone
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            mtval <= '0;
        else if (take_ex)
            mtval <= ex_tval;
    end

    // Interrupt enable stack
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (trap_taken) begin
            mstatus_mpie <= mstatus_mie;    // Push
            mstatus_mie  <= 1'b0;           // Handler runs masked
        end else if (mret) begin
            mstatus_mie  <= mstatus_mpie;   // Pop
            mstatus_mpie <= 1'b1;
        end else if (mstatus_wr) begin
            mstatus_mie  <= csr_wdata[`TRAP_MSTATUS_MIE];
            mstatus_mpie <= csr_wdata[`TRAP_MSTATUS_MPIE];
        end
    end

    // Held so trap stays up while the pipeline drains
    // A new take wins over a same-cycle pipe_clear
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            int_taken <= 1'b0;
        else if (take_int)
            int_taken <= 1'b1;
        else if (pipe_clear)
            int_taken <= 1'b0;
    end

endmodule

`default_nettype wire

// File: src/trap_unit.sv
/*
 * Machine-mode trap unit, top level
 * Interrupt and exception prioritizers feeding the trap control
 */
`timescale 1ns/1ns
`default_nettype none

`include "trap_cfg.svh"

module trap_unit (
    input  logic                   CLK,
    input  logic                   nRST,
    // Interrupt lines and their clears
    input  logic                   ext_irq,
    input  logic                   soft_irq,
    input  logic                   timer_irq,
    input  logic                   clr_ext,
    input  logic                   clr_soft,
    input  logic                   clr_timer,
    // Exception flags from the pipeline
    input  logic                   breakpoint,
    input  logic                   insn_access,
    input  logic                   illegal_insn,
    input  logic                   insn_mal,
    input  logic                   ecall_m,
    input  logic                   store_mal,
    input  logic                   load_mal,
    input  logic                   store_fault,
    input  logic                   load_fault,
    input  logic [`TRAP_XLEN-1:0]  epc,
    input  logic [`TRAP_XLEN-1:0]  bad_value,
    input  logic                   mret,
    input  logic                   pipe_clear,
    // Software write port
    input  logic                   csr_write,
    input  trap_pkg::csr_sel_t     csr_sel,
    input  logic [`TRAP_XLEN-1:0]  csr_wdata,
    output logic                   trap,
    output trap_pkg::mcause_u      mcause,
    output logic [`TRAP_XLEN-1:0]  mepc,
    output logic [`TRAP_XLEN-1:0]  mtval,
    output logic                   mstatus_mie,
    output logic                   mstatus_mpie,
    output logic [2:0]             mie_bits,
    output logic [2:0]             mip
);

    logic                   int_pending;
    trap_pkg::int_code_t    int_code;
    logic                   ex_valid;
    trap_pkg::ex_code_t     ex_code;
    logic [`TRAP_XLEN-1:0]  ex_tval;

    int_prioritizer u_int (
        .CLK(CLK), .nRST(nRST),
        .ext_irq(ext_irq), .soft_irq(soft_irq), .timer_irq(timer_irq),
        .clr_ext(clr_ext), .clr_soft(clr_soft), .clr_timer(clr_timer),
        .csr_write(csr_write), .csr_sel(csr_sel), .csr_wdata(csr_wdata),
        .mip(mip), .mie_bits(mie_bits),
        .int_pending(int_pending), .int_code(int_code)
    );

    ex_prioritizer u_ex (
        .breakpoint(breakpoint), .insn_access(insn_access),
        .illegal_insn(illegal_insn), .insn_mal(insn_mal), .ecall_m(ecall_m),
        .store_mal(store_mal), .load_mal(load_mal),
        .store_fault(store_fault), .load_fault(load_fault),
        .bad_value(bad_value),
        .ex_valid(ex_valid), .ex_code(ex_code), .ex_tval(ex_tval)
    );

    trap_ctrl u_ctrl (
        .CLK(CLK), .nRST(nRST),
        .int_pending(int_pending), .int_code(int_code),
        .ex_valid(ex_valid), .ex_code(ex_code), .ex_tval(ex_tval),
        .epc(epc), .mret(mret), .pipe_clear(pipe_clear),
        .csr_write(csr_write), .csr_sel(csr_sel), .csr_wdata(csr_wdata),
        .trap(trap), .mcause(mcause), .mepc(mepc), .mtval(mtval),
        .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie)
    );

endmodule

`default_nettype wire

// File: bench/trap_unit_chk.sv
/*
 * Trap control assertions
 * Bound into trap_ctrl, watches the enable stack, int_taken and mepc
 */
`timescale 1ns/1ns
`default_nettype none

`include "trap_cfg.svh"

module trap_unit_chk (
    input logic                   CLK,
    input logic                   nRST,
    input logic                   trap_taken,
    input logic                   int_taken,
    input logic                   pipe_clear,
    input logic                   mstatus_mie,
    input logic [`TRAP_XLEN-1:0]  mepc
);

    int fails = 0;  // Read by the testbench at the end

    // Handler always starts masked
    mie_cleared: assert property (@(posedge CLK) disable iff (!nRST)
        trap_taken |=> !mstatus_mie)
        else begin
            $error("mstatus.mie still set after a taken trap");
            fails++;
        end

    // Latched interrupt is released only by the pipeline
    held_until_clear: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(int_taken) |-> $past(pipe_clear))
        else begin
            $error("int_taken dropped without pipe_clear");
            fails++;
        end

    mepc_on_trap: assert property (@(posedge CLK) disable iff (!nRST)
        !$stable(mepc) |-> $past(trap_taken))
        else begin
            $error("mepc changed without a taken trap");
            fails++;
        end

endmodule

`default_nettype wire

// File: bench/trap_unit_monitor.sv
/*
 * Trap unit reference model and output checker
 * Cycle model of mip, enables, enable stack and trap CSRs
 * Every DUT output is compared on each falling clock edge
 */
`timescale 1ns/1ns
`default_nettype none

`include "trap_cfg.svh"

module trap_unit_monitor (
    input logic                   CLK, nRST,
    input logic [2:0]             test_id,
    input logic                   ext_irq, soft_irq, timer_irq,
    input logic                   clr_ext, clr_soft, clr_timer,
    input logic                   breakpoint, insn_access, illegal_insn, insn_mal, ecall_m,
    input logic                   store_mal, load_mal, store_fault, load_fault,
    input logic [`TRAP_XLEN-1:0]  epc, bad_value, csr_wdata,
    input logic                   mret, pipe_clear, csr_write,
    input trap_pkg::csr_sel_t     csr_sel,
    input logic                   trap,
    input trap_pkg::mcause_u      mcause,
    input logic [`TRAP_XLEN-1:0]  mepc, mtval,
    input logic                   mstatus_mie, mstatus_mpie,
    input logic [2:0]             mie_bits, mip
);

    int errors = 0;
    int checks = 0;

    logic [2:0]             m_mip;
    logic [2:0]             m_en;
    logic                   m_mie;
    logic                   m_mpie;
    logic                   m_int_taken;
    trap_pkg::mcause_u      m_cause;
    logic [`TRAP_XLEN-1:0]  m_mepc;
    logic [`TRAP_XLEN-1:0]  m_mtval;
    logic [8:0]             ex_flags;   // Index 0 is most urgent
    logic                   ex_hit;
    int                     ex_idx;
    logic [2:0]             active;
    logic                   take_int;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "exception_priority";
            3'd2:    return "interrupt_priority";
            3'd3:    return "masking";
            3'd4:    return "stack";
            default: return "random";
        endcase
    endfunction

    // Cause code by priority slot
    function automatic logic [4:0] ex_cause(input int idx);
        case (idx)
            0:       return 5'(`TRAP_EX_BREAKPOINT);
            1:       return 5'(`TRAP_EX_INSN_ACCESS);
            2:       return 5'(`TRAP_EX_ILLEGAL);
            3:       return 5'(`TRAP_EX_INSN_MAL);
            4:       return 5'(`TRAP_EX_ECALL_M);
            5:       return 5'(`TRAP_EX_STORE_MAL);
            6:       return 5'(`TRAP_EX_LOAD_MAL);
            7:       return 5'(`TRAP_EX_STORE_FAULT);
            default: return 5'(`TRAP_EX_LOAD_FAULT);
        endcase
    endfunction

    function automatic logic [3:0] int_cause(input logic [2:0] act);
        if (act[`TRAP_IP_EXT])
            return 4'(`TRAP_INT_EXT);
        if (act[`TRAP_IP_SOFT])
            return 4'(`TRAP_INT_SOFT);
        return 4'(`TRAP_INT_TIMER);
    endfunction

    assign ex_flags = {load_fault, store_fault, load_mal, store_mal, ecall_m,
                       insn_mal, illegal_insn, insn_access, breakpoint};

    // Scan from the least urgent slot so the most urgent set slot is left in ex_idx
    always_comb begin
        ex_hit = 1'b0;
        ex_idx = 0;
        for (int i = 8; i >= 0; i--) begin
            if (ex_flags[i]) begin
                ex_hit = 1'b1;
                ex_idx = i;
            end
        end
    end

    assign active   = m_mip & m_en;
    assign take_int = !ex_hit && m_mie && (active != 3'b000);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            m_mip       <= '0;
            m_en        <= '0;
            m_mie       <= 1'b0;
            m_mpie      <= 1'b0;
            m_int_taken <= 1'b0;
            m_cause     <= '0;
            m_mepc      <= '0;
            m_mtval     <= '0;
        end else begin
            m_mip[`TRAP_IP_EXT]   <= ext_irq   | (m_mip[`TRAP_IP_EXT]   & ~clr_ext);
            m_mip[`TRAP_IP_SOFT]  <= soft_irq  | (m_mip[`TRAP_IP_SOFT]  & ~clr_soft);
            m_mip[`TRAP_IP_TIMER] <= timer_irq | (m_mip[`TRAP_IP_TIMER] & ~clr_timer);
            if (csr_write && csr_sel == trap_pkg::CSR_MIE)
                m_en <= {csr_wdata[`TRAP_INT_EXT], csr_wdata[`TRAP_INT_TIMER],
                         csr_wdata[`TRAP_INT_SOFT]};
            if (ex_hit || take_int) begin       // Any trap pushes the stack
                m_mepc <= epc;
                m_mpie <= m_mie;
                m_mie  <= 1'b0;
            end else if (mret) begin
                m_mie  <= m_mpie;
                m_mpie <= 1'b1;
            end else if (csr_write && csr_sel == trap_pkg::CSR_MSTATUS) begin
                m_mie  <= csr_wdata[`TRAP_MSTATUS_MIE];
                m_mpie <= csr_wdata[`TRAP_MSTATUS_MPIE];
            end
            if (ex_hit) begin
                m_cause.exc.intr <= 1'b0;
                m_cause.exc.pad  <= '0;
                m_cause.exc.code <= trap_pkg::ex_code_t'(ex_cause(ex_idx));
                m_mtval <= (ex_idx == 0 || ex_idx == 4) ? '0 : bad_value;  // Zero for break and ecall
            end else if (take_int) begin
                m_cause.irq.intr <= 1'b1;
                m_cause.irq.pad  <= '0;
                m_cause.irq.code <= trap_pkg::int_code_t'(int_cause(active));
            end
            if (take_int)
                m_int_taken <= 1'b1;
            else if (pipe_clear)
                m_int_taken <= 1'b0;
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h at %0t",
                     test_name(test_id), what, exp, act, $time);
        end
    endtask

    // Sampled mid-cycle where inputs and registers are settled
    always @(negedge CLK) begin
        if (nRST) begin
            check("trap", 32'(ex_hit | m_int_taken), 32'(trap));
            check("mcause.intr", 32'(m_cause.irq.intr), 32'(mcause.irq.intr));
            if (mcause.irq.intr) begin  // View picked by the top bit
                check("mcause.irq.pad", 32'(m_cause.irq.pad), 32'(mcause.irq.pad));
                check("mcause.irq.code", 32'(m_cause.irq.code), 32'(mcause.irq.code));
            end else begin
                check("mcause.exc.pad", 32'(m_cause.exc.pad), 32'(mcause.exc.pad));
                check("mcause.exc.code", 32'(m_cause.exc.code), 32'(mcause.exc.code));
            end
            check("mepc", m_mepc, mepc);
            check("mtval", m_mtval, mtval);
            check("mstatus_mie", 32'(m_mie), 32'(mstatus_mie));
            check("mstatus_mpie", 32'(m_mpie), 32'(mstatus_mpie));
            check("mie_bits", 32'(m_en), 32'(mie_bits));
            check("mip", 32'(m_mip), 32'(mip));
        end
    end

endmodule

`default_nettype wire

// File: bench/trap_unit_tb.sv
/*
 * Trap unit testbench
 * Directed phases then LFSR random stimulus, checked by the monitor
 * and by assertions bound into trap_ctrl
 */
`timescale 1ns/1ns
`default_nettype none

`include "trap_cfg.svh"

module trap_unit_tb;

    localparam int NUM_CYCLES = 2000;
    localparam logic [31:0] ALL_EN = (32'd1 << `TRAP_INT_EXT) | (32'd1 << `TRAP_INT_TIMER) |
                                     (32'd1 << `TRAP_INT_SOFT);

    logic                   CLK, nRST;
    logic                   ext_irq, soft_irq, timer_irq;
    logic                   clr_ext, clr_soft, clr_timer;
    logic                   breakpoint, insn_access, illegal_insn, insn_mal, ecall_m;
    logic                   store_mal, load_mal, store_fault, load_fault;
    logic [`TRAP_XLEN-1:0]  epc, bad_value, csr_wdata;
    logic                   mret, pipe_clear, csr_write;
    trap_pkg::csr_sel_t     csr_sel;
    logic                   trap;
    trap_pkg::mcause_u      mcause;
    logic [`TRAP_XLEN-1:0]  mepc, mtval;
    logic                   mstatus_mie, mstatus_mpie;
    logic [2:0]             mie_bits, mip;
    logic [2:0]             test_id;
    logic [15:0]            lfsr = 16'd47;
    int                     cycles = 0;
    int                     total;

    trap_unit uut (.*);
    trap_unit_monitor mon (.*);

    bind trap_ctrl trap_unit_chk chk_i (
        .CLK(CLK), .nRST(nRST), .trap_taken(trap_taken), .int_taken(int_taken),
        .pipe_clear(pipe_clear), .mstatus_mie(mstatus_mie), .mepc(mepc)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Galois LFSR, one step per bit
    function automatic logic rbit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    function automatic logic [31:0] rword();
        logic [31:0] w;
        for (int i = 0; i < 32; i++)
            w[i] = rbit();
        return w;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge CLK);
        #5;
        cycles += n;
    endtask

    // Bit 0 is the most urgent exception
    task automatic set_flags(input logic [8:0] f);
        breakpoint   = f[0];
        insn_access  = f[1];
        illegal_insn = f[2];
        insn_mal     = f[3];
        ecall_m      = f[4];
        store_mal    = f[5];
        load_mal     = f[6];
        store_fault  = f[7];
        load_fault   = f[8];
    endtask

    task automatic clear_strobes();
        set_flags('0);
        {clr_ext, clr_soft, clr_timer} = 3'b000;
        {mret, pipe_clear, csr_write}  = 3'b000;
    endtask

    task automatic write_csr(input trap_pkg::csr_sel_t sel, input logic [31:0] d);
        csr_write = 1'b1;
        csr_sel   = sel;
        csr_wdata = d;
        tick(1);
        csr_write = 1'b0;
    endtask

    // Let trap hold, drain, clear the source and return; which uses mip order
    task automatic serve_irq(input logic [2:0] which);
        tick(2);
        pipe_clear = 1'b1;
        {clr_ext, clr_timer, clr_soft} = which;
        tick(1);
        clear_strobes();
        mret = 1'b1;
        tick(1);
        clear_strobes();
    endtask

    task automatic random_cycle();
        logic [8:0] f;
        for (int i = 0; i < 9; i++)
            f[i] = rbit() & rbit() & rbit() & rbit() & rbit();  // Rare
        set_flags(f);
        ext_irq    = rbit() & rbit();
        soft_irq   = rbit() & rbit();
        timer_irq  = rbit() & rbit();
        clr_ext    = rbit() & rbit();
        clr_soft   = rbit() & rbit();
        clr_timer  = rbit() & rbit();
        epc        = rword();
        bad_value  = rword();
        mret       = rbit() & rbit() & rbit();
        pipe_clear = rbit() & rbit();
        csr_write  = rbit() & rbit() & rbit();
        csr_sel    = rbit() ? trap_pkg::CSR_MIE : trap_pkg::CSR_MSTATUS;
        csr_wdata  = rword();
    endtask

    initial begin
        logic [31:0] w;
        nRST = 1'b0;
        test_id = 3'd0;
        {ext_irq, soft_irq, timer_irq} = 3'b000;
        clear_strobes();
        epc       = '0;
        bad_value = '0;
        csr_wdata = '0;
        csr_sel   = trap_pkg::CSR_MSTATUS;
        repeat (5) @(posedge CLK);
        #5 nRST = 1'b1;

        // Set beats a same-cycle clear, then a plain clear
        ext_irq = 1'b1;
        clr_ext = 1'b1;
        soft_irq = 1'b1;
        tick(1);
        {ext_irq, soft_irq} = 2'b00;
        tick(2);
        clr_ext  = 1'b1;
        clr_soft = 1'b1;
        tick(1);
        clear_strobes();
        tick(1);

        // Each flag wins once against random lower ones
        test_id = 3'd1;
        for (int k = 0; k < 9; k++) begin
            w = rword();
            set_flags(9'(1 << k) | (w[8:0] & ~9'((1 << (k + 1)) - 1)));
            epc       = rword();
            bad_value = rword();
            tick(1);
        end
        clear_strobes();
        tick(1);

        test_id = 3'd2;
        write_csr(trap_pkg::CSR_MIE, ALL_EN);
        write_csr(trap_pkg::CSR_MSTATUS, 32'd1 << `TRAP_MSTATUS_MIE);
        {ext_irq, soft_irq, timer_irq} = 3'b111;
        tick(1);
        {ext_irq, soft_irq, timer_irq} = 3'b000;
        tick(1);
        serve_irq(3'b100);  // ext, then soft, then timer
        serve_irq(3'b001);
        serve_irq(3'b010);

        test_id = 3'd3;
        write_csr(trap_pkg::CSR_MSTATUS, 32'd0);   // Globally off
        soft_irq = 1'b1;
        tick(1);
        soft_irq = 1'b0;
        tick(4);
        clr_soft = 1'b1;
        tick(1);
        clr_soft = 1'b0;
        write_csr(trap_pkg::CSR_MIE, 32'd1 << `TRAP_INT_EXT);
        write_csr(trap_pkg::CSR_MSTATUS, 32'd1 << `TRAP_MSTATUS_MIE);
        timer_irq = 1'b1;   // Timer not enabled
        tick(1);
        timer_irq = 1'b0;
        tick(4);
        clr_timer = 1'b1;
        tick(1);
        clr_timer = 1'b0;

        // Exception and interrupt in the same cycle
        test_id = 3'd4;
        write_csr(trap_pkg::CSR_MIE, ALL_EN);
        ext_irq = 1'b1;
        tick(1);
        ext_irq      = 1'b0;
        illegal_insn = 1'b1;
        epc          = rword();
        bad_value    = rword();
        tick(1);
        illegal_insn = 1'b0;
        tick(2);
        mret = 1'b1;    // Unmasks, the pending ext is taken next
        tick(1);
        mret = 1'b0;
        serve_irq(3'b100);

        test_id = 3'd5;
        while (cycles < NUM_CYCLES) begin
            random_cycle();
            tick(1);
        end
        clear_strobes();
        repeat (2) @(posedge CLK);

        total = mon.errors + uut.u_ctrl.chk_i.fails;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 mon.checks, mon.errors, uut.u_ctrl.chk_i.fails);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog sized from the test length
    initial begin
        #((NUM_CYCLES + 100) * 100);
        $display("Watchdog: simulation did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: trap_unit.f
+incdir+src
src/trap_pkg.sv
src/int_prioritizer.sv
src/ex_prioritizer.sv
src/trap_ctrl.sv
src/trap_unit.sv
bench/trap_unit_chk.sv
bench/trap_unit_monitor.sv
bench/trap_unit_tb.sv

// File: Makefile
# Verilator build and run of the trap unit testbench
VERILATOR ?= verilator
TOP       ?= trap_unit_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= trap_unit.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= RESULT: PASS

SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from a search of the simulator output
run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
